// ==== design/byte_window_consts.svh ====
`ifndef BYTE_WINDOW_CONSTS_SVH
`define BYTE_WINDOW_CONSTS_SVH

// datapath widths
`define BW_WORD_W        32
`define BW_ADDR_W        32
`define BW_FILL_W        4
`define BW_MLEN_W        3

// store geometry and load thresholds
`define BW_STORE_BYTES   12
`define BW_WINDOW_BYTES  4
`define BW_LOAD_LIMIT    8
`define BW_INIT_WORDS    1

// byte address at reset and at session start
`define BW_ADDR_RST      32'h0000_0000

`endif

// ==== design/byte_window_pkg.sv ====
`include "byte_window_consts.svh"

package byte_window_pkg;

	////////////////////
	// plain vectors
	////////////////////

	typedef logic [`BW_WORD_W-1:0] word_t;
	typedef logic [`BW_ADDR_W-1:0] addr_t;
	typedef logic [`BW_FILL_W-1:0] fill_t;
	typedef logic [`BW_MLEN_W-1:0] match_len_t;

	////////////////////
	// bundles
	////////////////////

	// word entering the store
	typedef struct packed {
		logic  valid;
		word_t data;
	} load_t;

	// consumer request, at most one strobe high
	typedef struct packed {
		logic       shift;
		logic       dword;
		match_len_t match_len;
	} req_t;

	// window response with its byte address
	typedef struct packed {
		logic  svalid;
		logic  dvalid;
		word_t data;
		addr_t addr;
	} resp_t;

	typedef enum logic [1:0] {IDLE, WAIT_INIT, RUN, DONE} ctrl_state_t;

endpackage

// ==== design/fifo_word_loader.sv ====
`timescale 1ns/100ps
`include "byte_window_consts.svh"

module fifo_word_loader
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    session_active,
	input  byte_window_pkg::fill_t  fill,
	input  byte_window_pkg::word_t  fifo_data,
	input  logic                    fifo_valid,
	input  logic                    fifo_empty,
	output logic                    rd_fifo_en,
	output byte_window_pkg::load_t  load
);

	logic                   rd_pend;
	logic                   load_valid_q;
	byte_window_pkg::word_t load_data_q;
	logic                   room;

	// a word still fits after the in-flight one lands
	assign room = fill <= byte_window_pkg::fill_t'(`BW_LOAD_LIMIT - `BW_WINDOW_BYTES);

	// one read at a time, until its word reaches the store
	assign rd_fifo_en = session_active && !fifo_empty && !rd_pend && !load_valid_q && room;

	////////////////////
	// read tracking
	////////////////////

	// the FIFO answers in the next cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rd_pend <= 1'b0;
		else
			rd_pend <= rd_fifo_en;
	end

	// late words after a session end are dropped here
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			load_valid_q <= 1'b0;
		else
			load_valid_q <= fifo_valid && session_active;
	end

	always_ff @(posedge clk)
	begin
		if (fifo_valid)
			load_data_q <= fifo_data;
	end

	assign load = '{valid: load_valid_q, data: load_data_q};

	////////////////////
	// checks
	////////////////////

	// returned word lines up with our own read
	a_word_follows_read: assert property (@(posedge clk) disable iff (!rstN)
		fifo_valid |-> rd_pend);

endmodule

// ==== design/byte_shift_store.sv ====
`timescale 1ns/100ps
`include "byte_window_consts.svh"

module byte_shift_store
(
	input  logic                    clk,
	input  logic                    rstN,
	input  byte_window_pkg::load_t  load,
	input  byte_window_pkg::req_t   req,
	input  logic                    flush,
	output byte_window_pkg::fill_t  fill,
	output byte_window_pkg::word_t  top_word
);

	localparam int STORE_W = `BW_STORE_BYTES * 8;

	logic [STORE_W-1:0]     data_q;
	byte_window_pkg::fill_t fill_q;
	byte_window_pkg::fill_t adv;
	byte_window_pkg::fill_t kept;
	logic [STORE_W-1:0]     shifted;
	logic [STORE_W-1:0]     keep_mask;
	logic [STORE_W-1:0]     placed;

	////////////////////
	// next contents
	////////////////////

	always_comb
	begin
		adv = '0;
		if (req.shift)
			adv = byte_window_pkg::fill_t'(1);
		else if (req.dword)
			adv = byte_window_pkg::fill_t'(req.match_len);

		// bytes left after this cycle's advance
		kept = fill_q - adv;

		// oldest byte sits at the top
		shifted = data_q << {adv, 3'b000};

		// new word goes right behind the kept bytes
		keep_mask = ~({STORE_W{1'b1}} >> {kept, 3'b000});
		placed    = {load.data, {(STORE_W - `BW_WORD_W){1'b0}}} >> {kept, 3'b000};
	end

	////////////////////
	// storage
	////////////////////

	always_ff @(posedge clk)
	begin
		if (flush)
			data_q <= '0;
		else if (load.valid)
			data_q <= (shifted & keep_mask) | placed;
		else if (adv != '0)
			data_q <= shifted;
	end

	// a flush beats any append in the same cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			fill_q <= '0;
		end
		else if (flush)
		begin
			fill_q <= '0;
		end
		else if (load.valid)
		begin
			fill_q <= kept + byte_window_pkg::fill_t'(`BW_WINDOW_BYTES);
		end
		else
		begin
			fill_q <= kept;
		end
	end

	assign fill     = fill_q;
	assign top_word = data_q[STORE_W-1 -: `BW_WORD_W];

	////////////////////
	// checks
	////////////////////

	// loader threshold keeps us inside the store
	a_fill_in_range: assert property (@(posedge clk) disable iff (!rstN)
		fill_q <= byte_window_pkg::fill_t'(`BW_STORE_BYTES));

	// busy gating never lets a read run past the buffered bytes
	a_no_underflow: assert property (@(posedge clk) disable iff (!rstN)
		adv <= fill_q);

endmodule

// ==== design/window_ctrl.sv ====
`timescale 1ns/100ps
`include "byte_window_consts.svh"

module window_ctrl
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    byte4_en,
	input  byte_window_pkg::req_t   req_in,
	input  byte_window_pkg::fill_t  fill,
	input  byte_window_pkg::word_t  top_word,
	output logic                    session_active,
	output byte_window_pkg::req_t   req,
	output logic                    flush,
	output logic                    byte4_busy,
	output byte_window_pkg::resp_t  resp
);

	byte_window_pkg::ctrl_state_t state_q;
	byte_window_pkg::ctrl_state_t state_d;
	byte_window_pkg::addr_t       addr_q;
	byte_window_pkg::addr_t       resp_addr_q;
	byte_window_pkg::word_t       resp_data_q;
	logic                         svalid_q;
	logic                         dvalid_q;

	////////////////////
	// session FSM
	////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			byte_window_pkg::IDLE:
			begin
				if (byte4_en)
					state_d = byte_window_pkg::WAIT_INIT;
			end
			byte_window_pkg::WAIT_INIT:
			begin
				if (!byte4_en)
					state_d = byte_window_pkg::DONE;
				else if (fill >= byte_window_pkg::fill_t'(`BW_INIT_WORDS * `BW_WINDOW_BYTES))
					state_d = byte_window_pkg::RUN;
			end
			byte_window_pkg::RUN:
			begin
				if (!byte4_en)
					state_d = byte_window_pkg::DONE;
			end
			default:
			begin
				state_d = byte_window_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state_q <= byte_window_pkg::IDLE;
		else
			state_q <= state_d;
	end

	// loading only while a session is open
	assign session_active = byte4_en &&
		(state_q == byte_window_pkg::WAIT_INIT || state_q == byte_window_pkg::RUN);
	assign flush = state_q == byte_window_pkg::DONE;

	// a full window must be buffered
	assign byte4_busy = (state_q != byte_window_pkg::RUN) ||
		(fill < byte_window_pkg::fill_t'(`BW_WINDOW_BYTES));

	// requests seen while busy are ignored
	assign req = '{shift: req_in.shift && !byte4_busy, dword: req_in.dword && !byte4_busy,
		match_len: req_in.match_len};

	////////////////////
	// address and response
	////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			addr_q <= `BW_ADDR_RST;
		else if (flush)
			addr_q <= `BW_ADDR_RST;
		else if (req.shift)
			addr_q <= addr_q + byte_window_pkg::addr_t'(1);
		else if (req.dword)
			addr_q <= addr_q + byte_window_pkg::addr_t'(req.match_len);
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			svalid_q <= 1'b0;
			dvalid_q <= 1'b0;
		end
		else
		begin
			svalid_q <= req.shift;
			dvalid_q <= req.dword;
		end
	end

	// window as it stood before this advance
	always_ff @(posedge clk)
	begin
		resp_data_q <= top_word;
		resp_addr_q <= addr_q;
	end

	assign resp = '{svalid: svalid_q, dvalid: dvalid_q, data: resp_data_q, addr: resp_addr_q};

	a_one_valid: assert property (@(posedge clk) disable iff (!rstN)
		!(resp.svalid && resp.dvalid));

endmodule

// ==== design/byte_window_top.sv ====
`timescale 1ns/100ps

module byte_window_top
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        byte4_en,
	input  logic                        rd_shift_en,
	input  logic                        rd_dword_en,
	input  byte_window_pkg::match_len_t match_len,
	input  byte_window_pkg::word_t      fifo_data,
	input  logic                        fifo_valid,
	input  logic                        fifo_empty,
	output logic                        rd_fifo_en,
	output logic                        byte4_busy,
	output byte_window_pkg::resp_t      resp
);

	byte_window_pkg::req_t  consumer_req;
	byte_window_pkg::req_t  accepted_req;
	byte_window_pkg::load_t load;
	byte_window_pkg::fill_t fill;
	byte_window_pkg::word_t top_word;
	logic                   session_active;
	logic                   flush;

	// raw consumer strobes, qualified later by busy
	assign consumer_req = '{shift: rd_shift_en, dword: rd_dword_en, match_len: match_len};

	fifo_word_loader u_loader
	(
		.clk            (clk),
		.rstN           (rstN),
		.session_active (session_active),
		.fill           (fill),
		.fifo_data      (fifo_data),
		.fifo_valid     (fifo_valid),
		.fifo_empty     (fifo_empty),
		.rd_fifo_en     (rd_fifo_en),
		.load           (load)
	);

	byte_shift_store u_store
	(
		.clk      (clk),
		.rstN     (rstN),
		.load     (load),
		.req      (accepted_req),
		.flush    (flush),
		.fill     (fill),
		.top_word (top_word)
	);

	window_ctrl u_ctrl
	(
		.clk            (clk),
		.rstN           (rstN),
		.byte4_en       (byte4_en),
		.req_in         (consumer_req),
		.fill           (fill),
		.top_word       (top_word),
		.session_active (session_active),
		.req            (accepted_req),
		.flush          (flush),
		.byte4_busy     (byte4_busy),
		.resp           (resp)
	);

endmodule

// ==== verification/byte_window_checker.sv ====
`timescale 1ns/100ps

module byte_window_checker
(
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        byte4_en,
	input  logic                        rd_shift_en,
	input  logic                        rd_dword_en,
	input  byte_window_pkg::match_len_t match_len,
	input  byte_window_pkg::word_t      fifo_data,
	input  logic                        fifo_valid,
	input  logic                        fifo_empty,
	input  logic                        rd_fifo_en,
	input  logic                        byte4_busy,
	input  byte_window_pkg::resp_t      resp,
	output int                          error_count,
	output int                          check_count,
	output int                          session_count
);

	// words returned by the FIFO, in read order
	byte_window_pkg::word_t words[$];
	int                     issued;
	int                     ptr;
	int                     base;
	int                     exp_len;
	logic                   exp_pending;
	logic                   exp_shift;
	logic                   en_prev;
	logic                   busy_prev;
	logic                   started;
	int                     sess_checks;
	int                     sess_errors;
	int                     busy_edges;
	int                     idle_cycles;

	// big-endian byte of the popped stream
	function automatic logic [7:0] stream_byte(input int pos);
		byte_window_pkg::word_t w;
		w = words[pos / 4];
		return w[8 * (3 - pos % 4) +: 8];
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
		error_count++;
		sess_errors++;
	endtask

	task automatic report_fault(input string msg);
		$display("FAULT t=%0t %s", $time, msg);
		error_count++;
		sess_errors++;
	endtask

	////////////////////
	// response model
	////////////////////

	task automatic check_response();
		byte_window_pkg::word_t exp_data;
		byte_window_pkg::addr_t exp_addr;
		if (exp_pending)
		begin
			check_count++;
			sess_checks++;
			if (!resp.svalid && !resp.dvalid)
				report_fault("no response pulse in the cycle after an accepted request");
			else if (resp.svalid != exp_shift)
				report_value("resp.svalid", 32'(exp_shift), 32'(resp.svalid));
			else if (resp.dvalid == exp_shift)
				report_value("resp.dvalid", 32'(!exp_shift), 32'(resp.dvalid));
			else if (ptr + 4 > words.size() * 4)
				report_fault("window runs past the words popped from the FIFO");
			else
			begin
				exp_data = {stream_byte(ptr), stream_byte(ptr + 1), stream_byte(ptr + 2),
					stream_byte(ptr + 3)};
				exp_addr = byte_window_pkg::addr_t'(ptr - base);
				if (resp.data !== exp_data)
					report_value("resp.data", exp_data, resp.data);
				if (resp.addr !== exp_addr)
					report_value("resp.addr", exp_addr, resp.addr);
			end
			// the stream moves on even after a mismatch
			ptr = ptr + exp_len;
		end
		else if (resp.svalid || resp.dvalid)
			report_fault("response pulse without an accepted request");
	endtask

	task automatic check_fifo();
		if (rd_fifo_en)
		begin
			issued++;
			check_count++;
			if (fifo_empty)
				report_fault("rd_fifo_en high while the FIFO is empty");
		end
		if (fifo_valid)
			words.push_back(fifo_data);
	endtask

	// outside a session nothing loads and the window is busy
	task automatic check_idle();
		if (!started || (!byte4_en && !en_prev))
		begin
			idle_cycles++;
			check_count++;
			if (rd_fifo_en)
				report_value("rd_fifo_en", 32'(1'b0), 32'(rd_fifo_en));
			if (!byte4_busy)
				report_value("byte4_busy", 32'(1'b1), 32'(byte4_busy));
		end
	endtask

	task automatic track_session();
		if (byte4_en && !en_prev)
		begin
			if (!started)
				$display("reset idle: %0d cycles checked, %0d errors", idle_cycles, sess_errors);
			started     = 1'b1;
			sess_checks = 0;
			sess_errors = 0;
			busy_edges  = 0;
		end
		else if (byte4_en && en_prev && byte4_busy != busy_prev)
			busy_edges++;
		if (!byte4_en && en_prev)
		begin
			session_count++;
			$display("session %0d: %0d responses checked, %0d errors, busy toggled %0d times",
				session_count, sess_checks, sess_errors, busy_edges);
			// next session starts at the first word read after this one
			ptr  = issued * 4;
			base = ptr;
		end
		en_prev   = byte4_en;
		busy_prev = byte4_busy;
	endtask

	// everything is stable at the falling edge
	always @(negedge clk)
	begin
		if (!rstN)
		begin
			words.delete();
			issued        = 0;
			ptr           = 0;
			base          = 0;
			exp_len       = 0;
			exp_pending   = 1'b0;
			exp_shift     = 1'b0;
			en_prev       = 1'b0;
			busy_prev     = 1'b1;
			started       = 1'b0;
			sess_checks   = 0;
			sess_errors   = 0;
			busy_edges    = 0;
			idle_cycles   = 0;
			error_count   = 0;
			check_count   = 0;
			session_count = 0;
		end
		else
		begin
			check_response();
			exp_pending = (rd_shift_en || rd_dword_en) && !byte4_busy;
			exp_shift   = rd_shift_en;
			exp_len     = rd_shift_en ? 1 : int'(match_len);
			check_fifo();
			check_idle();
			track_session();
		end
	end

endmodule

// ==== verification/byte_window_tb.sv ====
`timescale 1ns/100ps

module byte_window_tb;

	localparam int NUM_SESSIONS    = 12;
	localparam int MAX_REQS        = 48;
	localparam int WATCHDOG_CYCLES = NUM_SESSIONS * MAX_REQS * 40 + 2000;

	logic                        clk = 1'b0;
	logic                        rstN;
	logic                        byte4_en;
	logic                        rd_shift_en;
	logic                        rd_dword_en;
	byte_window_pkg::match_len_t match_len;
	byte_window_pkg::word_t      fifo_data;
	logic                        fifo_valid;
	logic                        fifo_empty;
	logic                        rd_fifo_en;
	logic                        byte4_busy;
	byte_window_pkg::resp_t      resp;

	int                          seed;
	logic                        starved;
	logic                        read_seen;
	byte_window_pkg::word_t      fifo_q[$];
	int                          error_count;
	int                          check_count;
	int                          session_count;

	always #10 clk = ~clk;

	byte_window_top uut
	(
		.clk         (clk),
		.rstN        (rstN),
		.byte4_en    (byte4_en),
		.rd_shift_en (rd_shift_en),
		.rd_dword_en (rd_dword_en),
		.match_len   (match_len),
		.fifo_data   (fifo_data),
		.fifo_valid  (fifo_valid),
		.fifo_empty  (fifo_empty),
		.rd_fifo_en  (rd_fifo_en),
		.byte4_busy  (byte4_busy),
		.resp        (resp)
	);

	byte_window_checker u_checker
	(
		.clk           (clk),
		.rstN          (rstN),
		.byte4_en      (byte4_en),
		.rd_shift_en   (rd_shift_en),
		.rd_dword_en   (rd_dword_en),
		.match_len     (match_len),
		.fifo_data     (fifo_data),
		.fifo_valid    (fifo_valid),
		.fifo_empty    (fifo_empty),
		.rd_fifo_en    (rd_fifo_en),
		.byte4_busy    (byte4_busy),
		.resp          (resp),
		.error_count   (error_count),
		.check_count   (check_count),
		.session_count (session_count)
	);

	// the FIFO answers a read of this cycle right after the next edge
	always @(negedge clk)
		read_seen <= rd_fifo_en;

	////////////////////
	// FIFO model
	////////////////////

	task automatic next_cycle();
		logic [31:0] rnd;
		@(posedge clk);
		#2;
		fifo_valid = 1'b0;
		if (read_seen && fifo_q.size() > 0)
		begin
			fifo_data  = fifo_q.pop_front();
			fifo_valid = 1'b1;
		end
		rnd = $random(seed);
		// starved stretches come and go
		if (starved)
			starved = rnd[2:0] != 3'd0;
		else
			starved = rnd[4:0] == 5'd0;
		if (!starved && rnd[8] && fifo_q.size() < 6)
			fifo_q.push_back($random(seed));
		fifo_empty = fifo_q.size() == 0;
	endtask

	////////////////////
	// consumer model
	////////////////////

	task automatic run_session(input int num_reqs);
		logic [31:0] rnd;
		int          sent;
		sent     = 0;
		byte4_en = 1'b1;
		while (sent < num_reqs)
		begin
			next_cycle();
			rnd         = $random(seed);
			rd_shift_en = 1'b0;
			rd_dword_en = 1'b0;
			match_len   = rnd[7:5];
			if (!byte4_busy && rnd[1:0] != 2'b00)
			begin
				if (rnd[2])
					rd_shift_en = 1'b1;
				else
				begin
					rd_dword_en = 1'b1;
					match_len   = {1'b0, rnd[4:3]} + 3'd1;
				end
				sent++;
			end
		end
		next_cycle();
		rd_shift_en = 1'b0;
		rd_dword_en = 1'b0;
		byte4_en    = 1'b0;
	endtask

	initial
	begin
		int          gap;
		int          s;
		logic [31:0] rnd;
		seed        = 32'h69bc_5154;
		rstN        = 1'b0;
		byte4_en    = 1'b0;
		rd_shift_en = 1'b0;
		rd_dword_en = 1'b0;
		match_len   = '0;
		fifo_data   = '0;
		fifo_valid  = 1'b0;
		fifo_empty  = 1'b1;
		starved     = 1'b0;
		repeat (10) next_cycle();
		rstN = 1'b1;
		repeat (3) next_cycle();
		for (s = 0; s < NUM_SESSIONS; s++)
		begin
			rnd = $random(seed);
			run_session(int'(rnd[5:0]) % (MAX_REQS + 1));
			gap = 2 + int'(rnd[9:8]);
			repeat (gap) next_cycle();
		end
		repeat (4) next_cycle();
		$display("totals: %0d sessions, %0d checks, %0d errors",
			session_count, check_count, error_count);
		if (error_count == 0 && check_count > 0 && session_count == NUM_SESSIONS)
			$display("All checks passed");
		else
		begin
			if (session_count != NUM_SESSIONS)
				$display("only %0d of %0d sessions were seen", session_count, NUM_SESSIONS);
			$display("Checks failed");
		end
		$finish;
	end

	// run length bound from the request budget
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== byte_window.f ====
+incdir+design
design/byte_window_pkg.sv
design/fifo_word_loader.sv
design/byte_shift_store.sv
design/window_ctrl.sv
design/byte_window_top.sv
verification/byte_window_checker.sv
verification/byte_window_tb.sv

// ==== Makefile ====
TOP := byte_window_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then \
		echo "simulation FAILED, see sim.log"; \
		exit 1; \
	else \
		echo "simulation ok"; \
	fi

obj_dir/V$(TOP): byte_window.f design/*.sv design/*.svh verification/*.sv
	verilator --binary --timing --assert -f byte_window.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f byte_window.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
